// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FLIST     ?= rv_core.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^sim passed$$" $(LOG); then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/core_ref.svh
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

   ////////////////////////////////////////////////////////////////////////
   // operation codes of the generated program
   ////////////////////////////////////////////////////////////////////////
   // add through lw are the ops that write rd
   localparam int op_add  = 0;
   localparam int op_sub  = 1;
   localparam int op_and  = 2;
   localparam int op_or   = 3;
   localparam int op_xor  = 4;
   localparam int op_addi = 5;
   localparam int op_lw   = 6;
   localparam int op_sw   = 7;
   localparam int op_beq  = 8;
   localparam int op_bne  = 9;

   int unsigned rng_state;

   // lcg step, then a value in 0..n-1
   function automatic int unsigned rand_below(input int unsigned n);
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return (rng_state >> 8) % n;
   endfunction

   // rv32i encodings
   function automatic logic [31:0] encode(input int op, input int rd, input int rs1,
                                          input int rs2, input int imm);
      logic [4:0]  d;
      logic [4:0]  s1;
      logic [4:0]  s2;
      logic [31:0] im;
      d  = rd[4:0];
      s1 = rs1[4:0];
      s2 = rs2[4:0];
      im = imm;
      case (op)
         op_add:  return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
         op_sub:  return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
         op_and:  return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
         op_or:   return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
         op_xor:  return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
         op_addi: return {im[11:0], s1, 3'b000, d, 7'b0010011};
         op_lw:   return {im[11:0], s1, 3'b010, d, 7'b0000011};
         op_sw:   return {im[11:5], s2, s1, 3'b010, im[4:0], 7'b0100011};
         op_beq:  return {im[12], im[10:5], s2, s1, 3'b000, im[4:1], im[11], 7'b1100011};
         op_bne:  return {im[12], im[10:5], s2, s1, 3'b001, im[4:1], im[11], 7'b1100011};
         default: return 32'h0000_0013;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // instruction-set model, runs the program in order
   ////////////////////////////////////////////////////////////////////////
   function automatic int run_reference();
      logic [31:0] regs [32];
      logic [31:0] mem [1024];
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] addr;
      logic        taken;
      int          pc;
      int          next;
      int          steps;
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < 1024; i++) begin
         mem[i] = fill_word(i);
      end
      pc    = 0;
      steps = 0;
      while (pc < prog_len) begin
         a     = regs[prog_rs1[pc]];
         b     = regs[prog_rs2[pc]];
         addr  = a + prog_imm[pc];
         next  = pc + 1;
         res   = '0;
         taken = 1'b0;
         steps++;
         case (prog_op[pc])
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_addi: res = addr;
            op_lw:   res = mem[addr[11:2]];
            op_sw: begin
               mem[addr[11:2]] = b;
               exp_addr.push_back(addr[11:2]);
               exp_data.push_back(b);
            end
            op_beq:  taken = (a == b);
            op_bne:  taken = (a != b);
            default: res = '0;
         endcase
         // x0 never changes
         if (prog_op[pc] <= op_lw && prog_rd[pc] != 0) begin
            regs[prog_rd[pc]] = res;
         end
         if (taken) begin
            // branch to itself ends the program
            if (prog_imm[pc] == 0) begin
               break;
            end
            next = pc + prog_imm[pc] / 4;
         end
         pc = next;
      end
      return steps;
   endfunction

`endif

// File: bench/core_tb.sv
module core_tb;

   localparam int          rom_words    = 512;
   localparam int          ram_words    = 1024;
   localparam int          block_count  = 60;
   localparam int unsigned seed         = 57;
   localparam int          drain_cycles = 10;

   logic        clk;
   logic        rstn;
   logic [31:0] rom_addr;
   logic [31:0] rom_data;
   logic        ram_en;
   logic        ram_we;
   logic [9:0]  ram_addr;
   logic [31:0] ram_wdata;
   logic [31:0] ram_rdata = '0;

   logic [31:0] rom [rom_words];
   logic [31:0] ram [ram_words];
   logic        read_pending = 1'b0;
   logic [9:0]  read_addr = '0;

   // program fields that get encoded into the rom
   int prog_op  [rom_words];
   int prog_rd  [rom_words];
   int prog_rs1 [rom_words];
   int prog_rs2 [rom_words];
   int prog_imm [rom_words];
   int prog_len = 0;

   // expected stores and the writes seen on the ram port
   logic [9:0]  exp_addr [$];
   logic [31:0] exp_data [$];
   logic [9:0]  seen_addr [$];
   logic [31:0] seen_data [$];

   int ref_steps   = 0;
   int cycle_limit = 0;
   int cycles      = 0;
   bit done        = 1'b0;

   // ram start contents depend on every address bit
   function automatic logic [31:0] fill_word(input int a);
      return (32'(a) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
   endfunction

   `include "core_ref.svh"

   rv_core u_dut (
      .clk       (clk),
      .rstn      (rstn),
      .rom_addr  (rom_addr),
      .rom_data  (rom_data),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   assign rom_data = rom[rom_addr[10:2]];

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("ERR %s got 0x%08h expected 0x%08h", name, got, want);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   function automatic void emit(input int op, input int rd, input int rs1, input int rs2,
                                input int imm);
      prog_op[prog_len]  = op;
      prog_rd[prog_len]  = rd;
      prog_rs1[prog_len] = rs1;
      prog_rs2[prog_len] = rs2;
      prog_imm[prog_len] = imm;
      prog_len++;
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // program generation
   ////////////////////////////////////////////////////////////////////////
   function automatic void build_program();
      int ra;
      int rb;
      int rc;
      int slot_a;
      int slot_b;
      int br_op;
      // nonzero start values
      for (int r = 1; r < 32; r++) begin
         emit(op_addi, r, 0, 0, int'(rand_below(4096)) - 2048);
      end
      for (int blk = 0; blk < block_count; blk++) begin
         ra     = int'(rand_below(31)) + 1;
         rb     = int'(rand_below(31)) + 1;
         rc     = int'(rand_below(32));
         slot_a = int'(rand_below(512)) * 4;
         slot_b = int'(rand_below(512)) * 4;
         case (blk % 5)
            0: begin
               emit(int'(rand_below(6)), ra, rb, rc, int'(rand_below(4096)) - 2048);
               emit(op_sw, 0, 0, ra, slot_a);
            end
            1: begin
               // each op needs the one before it
               emit(op_addi, ra, rb, 0, int'(rand_below(4096)) - 2048);
               emit(op_xor, rb, ra, rc, 0);
               emit(op_sub, ra, rb, ra, 0);
               emit(op_sw, 0, 0, ra, slot_a);
            end
            2: begin
               emit(op_lw, ra, 0, 0, slot_a);
               emit(op_add, rb, ra, rc, 0);
               emit(op_sw, 0, 0, rb, slot_b);
            end
            3: begin
               br_op = (rand_below(2) == 0) ? op_beq : op_bne;
               if (rand_below(2) == 0) begin
                  rc = rb;
               end
               // taken skips the next two
               emit(br_op, 0, rb, rc, 12);
               emit(op_sw, 0, 0, rb, slot_a);
               emit(op_addi, ra, ra, 0, 1);
               emit(op_sw, 0, 0, ra, slot_b);
            end
            default: begin
               emit(op_add, 0, rb, rc, 0);
               emit(op_addi, 0, 0, 0, int'(rand_below(2047)) + 1);
               emit(op_sw, 0, 0, 0, slot_a);
            end
         endcase
      end
      emit(op_beq, 0, 0, 0, 0);
   endfunction

   // ram model with one cycle of read latency and mid-cycle sampling
   always @(negedge clk) begin
      if (read_pending) begin
         ram_rdata = ram[read_addr];
      end
      read_pending = ram_en && !ram_we;
      read_addr    = ram_addr;
      if (ram_we) begin
         ram[ram_addr] = ram_wdata;
         seen_addr.push_back(ram_addr);
         seen_data.push_back(ram_wdata);
      end
   end

   // compare each ram write with the next expected store
   always @(posedge clk) begin
      while (seen_addr.size() > 0) begin
         if (exp_addr.size() == 0) begin
            $display("unexpected RAM write to word 0x%03h after the last store", seen_addr[0]);
            $display("sim failed");
            $fatal(1);
         end else begin
            check("ram_addr", 32'(seen_addr[0]), 32'(exp_addr[0]));
            check("ram_wdata", seen_data[0], exp_data[0]);
            void'(seen_addr.pop_front());
            void'(seen_data.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            if (exp_addr.size() == 0) begin
               done = 1'b1;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (!done && cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, the expected stores did not all arrive", cycles);
         $display("sim failed");
         $fatal(1);
      end
   end

   initial begin
      rstn      = 1'b1;
      rng_state = seed;
      build_program();
      for (int i = 0; i < rom_words; i++) begin
         if (i < prog_len) begin
            rom[i] = encode(prog_op[i], prog_rd[i], prog_rs1[i], prog_rs2[i], prog_imm[i]);
         end else begin
            rom[i] = 32'h0000_0013;
         end
      end
      for (int i = 0; i < ram_words; i++) begin
         ram[i] = fill_word(i);
      end
      ref_steps   = run_reference();
      cycle_limit = 8 * ref_steps + 100;
      repeat (3) @(posedge clk);
      @(negedge clk);
      // still in reset with nothing fetched yet
      check("rom_addr", rom_addr, core_pkg::reset_pc);
      check("ram_we", 32'(ram_we), 32'h0);
      check("ram_en", 32'(ram_en), 32'h0);
      rstn = 1'b0;
      wait (done);
      // catch stray writes after the last store
      repeat (drain_cycles) @(negedge clk);
      $display("sim passed");
      $finish;
   end

endmodule

// File: rv_core.f
+incdir+bench
source/isa_pkg.sv
source/core_pkg.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_stage.sv
source/hazard_unit.sv
source/rv_core.sv
bench/core_tb.sv

// File: source/core_pkg.sv
package core_pkg;

   // first fetch address
   localparam logic [31:0] reset_pc = 32'h0000_0000;

   // data ram holds 1024 words
   localparam int ram_addr_w = 10;

   // where an execute operand comes from
   typedef enum logic [1:0] {
      fwd_none,
      fwd_mem,
      fwd_wb
   } fwd_src_e;

endpackage

// File: source/decode_stage.sv
module decode_stage (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           stall,
   input  logic                           flush,
   input  logic                           f_valid,
   input  logic [isa_pkg::xlen-1:0]       f_pc,
   input  logic [isa_pkg::xlen-1:0]       f_instr,
   output logic [isa_pkg::reg_addr_w-1:0] rs1_addr,
   output logic [isa_pkg::reg_addr_w-1:0] rs2_addr,
   input  logic [isa_pkg::xlen-1:0]       rs1_data,
   input  logic [isa_pkg::xlen-1:0]       rs2_data,
   output logic                           d_valid,
   output isa_pkg::opcode_e               d_op,
   output logic [isa_pkg::reg_addr_w-1:0] d_rd,
   output logic [isa_pkg::reg_addr_w-1:0] d_rs1,
   output logic [isa_pkg::reg_addr_w-1:0] d_rs2,
   output logic [isa_pkg::xlen-1:0]       d_rs1_data,
   output logic [isa_pkg::xlen-1:0]       d_rs2_data,
   output logic [isa_pkg::xlen-1:0]       d_imm,
   output logic [isa_pkg::xlen-1:0]       d_pc
);
   import isa_pkg::*;

   opcode_e         dec_op;
   logic [xlen-1:0] dec_imm;
   logic [6:0]      major;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic            uses_rs2;
   logic            writes_rd;

   assign major  = f_instr[6:0];
   assign funct3 = f_instr[14:12];
   assign funct7 = f_instr[31:25];

   ///////////////////////////////////////////////////////////////////////
   // opcode map, anything unknown is a nop
   ///////////////////////////////////////////////////////////////////////
   always_comb begin
      dec_op = op_nop;
      if (f_valid) begin
         case (major)
            major_op_op: begin
               if (funct7 == '0) begin
                  case (funct3)
                     funct3_add_sub: dec_op = op_add;
                     funct3_xor:     dec_op = op_xor;
                     funct3_or:      dec_op = op_or;
                     funct3_and:     dec_op = op_and;
                     default:        dec_op = op_nop;
                  endcase
               end else if (funct7 == funct7_sub && funct3 == funct3_add_sub) begin
                  dec_op = op_sub;
               end
            end
            major_op_imm: begin
               if (funct3 == funct3_add_sub) begin
                  dec_op = op_addi;
               end
            end
            major_op_load: begin
               if (funct3 == funct3_word) begin
                  dec_op = op_lw;
               end
            end
            major_op_store: begin
               if (funct3 == funct3_word) begin
                  dec_op = op_sw;
               end
            end
            major_op_branch: begin
               if (funct3 == funct3_beq) begin
                  dec_op = op_beq;
               end else if (funct3 == funct3_bne) begin
                  dec_op = op_bne;
               end
            end
            default: dec_op = op_nop;
         endcase
      end
   end

   // sign extended immediates
   always_comb begin
      case (dec_op)
         op_sw: begin
            dec_imm = {{20{f_instr[31]}}, f_instr[31:25], f_instr[11:7]};
         end
         op_beq, op_bne: begin
            dec_imm = {{19{f_instr[31]}}, f_instr[31], f_instr[7],
                       f_instr[30:25], f_instr[11:8], 1'b0};
         end
         default: begin
            dec_imm = {{20{f_instr[31]}}, f_instr[31:20]};
         end
      endcase
   end

   assign uses_rs2  = dec_op inside {op_add, op_sub, op_and, op_or, op_xor,
                                     op_sw, op_beq, op_bne};
   assign writes_rd = dec_op inside {op_add, op_sub, op_and, op_or, op_xor,
                                     op_addi, op_lw};

   // unused source fields read as x0 so they never match a hazard
   assign rs1_addr = (dec_op == op_nop) ? '0 : f_instr[19:15];
   assign rs2_addr = uses_rs2 ? f_instr[24:20] : '0;

   always_ff @(posedge clk) begin
      if (rstn || stall || flush) begin
         d_valid <= 1'b0;
      end else begin
         d_valid <= (dec_op != op_nop);
      end
   end

   always_ff @(posedge clk) begin
      d_op       <= dec_op;
      d_rd       <= writes_rd ? f_instr[11:7] : '0;
      d_rs1      <= rs1_addr;
      d_rs2      <= rs2_addr;
      d_rs1_data <= rs1_data;
      d_rs2_data <= rs2_data;
      d_imm      <= dec_imm;
      d_pc       <= f_pc;
   end

endmodule

// File: source/execute_stage.sv
module execute_stage (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           d_valid,
   input  isa_pkg::opcode_e               d_op,
   input  logic [isa_pkg::reg_addr_w-1:0] d_rd,
   input  logic [isa_pkg::reg_addr_w-1:0] d_rs1,
   input  logic [isa_pkg::reg_addr_w-1:0] d_rs2,
   input  logic [isa_pkg::xlen-1:0]       d_rs1_data,
   input  logic [isa_pkg::xlen-1:0]       d_rs2_data,
   input  logic [isa_pkg::xlen-1:0]       d_imm,
   input  logic [isa_pkg::xlen-1:0]       d_pc,
   input  core_pkg::fwd_src_e             fwd_a,
   input  core_pkg::fwd_src_e             fwd_b,
   input  logic [isa_pkg::xlen-1:0]       w_data,
   output logic                           redirect,
   output logic [isa_pkg::xlen-1:0]       redirect_pc,
   output logic                           e_valid,
   output isa_pkg::opcode_e               e_op,
   output logic [isa_pkg::reg_addr_w-1:0] e_rd,
   output logic [isa_pkg::xlen-1:0]       e_result,
   output logic [isa_pkg::xlen-1:0]       e_store_data
);
   import isa_pkg::*;
   import core_pkg::*;

   logic [xlen-1:0] op_a;
   logic [xlen-1:0] op_b;
   logic [xlen-1:0] alu_out;
   logic            taken;

   function automatic logic [xlen-1:0] pick_operand(input fwd_src_e sel,
                                                    input logic [xlen-1:0] reg_val);
      case (sel)
         fwd_mem: return e_result;
         fwd_wb:  return w_data;
         default: return reg_val;
      endcase
   endfunction

   assign op_a = pick_operand(fwd_a, d_rs1_data);
   assign op_b = pick_operand(fwd_b, d_rs2_data);

   always_comb begin
      case (d_op)
         op_add:  alu_out = op_a + op_b;
         op_sub:  alu_out = op_a - op_b;
         op_and:  alu_out = op_a & op_b;
         op_or:   alu_out = op_a | op_b;
         op_xor:  alu_out = op_a ^ op_b;
         // addi and the lw/sw address
         default: alu_out = op_a + d_imm;
      endcase
   end

   // branches predicted not taken, so only a taken one redirects
   assign taken = (d_op == op_beq && op_a == op_b) ||
                  (d_op == op_bne && op_a != op_b);
   assign redirect    = d_valid && taken;
   assign redirect_pc = d_pc + d_imm;

   always_ff @(posedge clk) begin
      if (rstn) begin
         e_valid <= 1'b0;
      end else begin
         e_valid <= d_valid;
      end
   end

   always_ff @(posedge clk) begin
      e_op         <= d_op;
      e_rd         <= d_rd;
      e_result     <= alu_out;
      e_store_data <= op_b;
   end

endmodule

// File: source/fetch_stage.sv
module fetch_stage (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     stall,
   input  logic                     redirect,
   input  logic [isa_pkg::xlen-1:0] redirect_pc,
   output logic [isa_pkg::xlen-1:0] rom_addr,
   input  logic [isa_pkg::xlen-1:0] rom_data,
   output logic                     f_valid,
   output logic [isa_pkg::xlen-1:0] f_pc,
   output logic [isa_pkg::xlen-1:0] f_instr
);
   import isa_pkg::*;
   import core_pkg::*;

   logic [xlen-1:0] pc;

   // rom answers in the same cycle
   assign rom_addr = pc;

   // redirect wins over a stall
   always_ff @(posedge clk) begin
      if (rstn) begin
         pc      <= reset_pc;
         f_valid <= 1'b0;
      end else if (redirect) begin
         pc      <= redirect_pc;
         f_valid <= 1'b0;
      end else if (!stall) begin
         pc      <= pc + instr_step;
         f_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         f_pc    <= pc;
         f_instr <= rom_data;
      end
   end

endmodule

// File: source/hazard_unit.sv
module hazard_unit (
   input  logic [isa_pkg::reg_addr_w-1:0] rs1_addr,
   input  logic [isa_pkg::reg_addr_w-1:0] rs2_addr,
   input  logic                           d_valid,
   input  isa_pkg::opcode_e               d_op,
   input  logic [isa_pkg::reg_addr_w-1:0] d_rd,
   input  logic [isa_pkg::reg_addr_w-1:0] d_rs1,
   input  logic [isa_pkg::reg_addr_w-1:0] d_rs2,
   input  logic                           e_valid,
   input  isa_pkg::opcode_e               e_op,
   input  logic [isa_pkg::reg_addr_w-1:0] e_rd,
   input  logic                           w_en,
   input  logic [isa_pkg::reg_addr_w-1:0] w_rd,
   input  logic                           redirect,
   output logic                           stall,
   output logic                           flush,
   output core_pkg::fwd_src_e             fwd_a,
   output core_pkg::fwd_src_e             fwd_b
);
   import isa_pkg::*;
   import core_pkg::*;

   logic mem_fwd_ok;

   // a load in execute/memory has no data yet, only alu results forward
   assign mem_fwd_ok = e_valid && e_op != op_lw && e_rd != '0;

   function automatic fwd_src_e pick_source(input logic [reg_addr_w-1:0] src);
      if (mem_fwd_ok && e_rd == src) begin
         return fwd_mem;
      end else if (w_en && w_rd == src) begin
         return fwd_wb;
      end
      return fwd_none;
   endfunction

   assign fwd_a = pick_source(d_rs1);
   assign fwd_b = pick_source(d_rs2);

   ///////////////////////////////////////////////////////////////////////
   // load-use holds decode for one cycle
   ///////////////////////////////////////////////////////////////////////
   assign stall = d_valid && d_op == op_lw && d_rd != '0 &&
                  (d_rd == rs1_addr || d_rd == rs2_addr);

   // wrong path sits in fetch and decode
   assign flush = redirect;

endmodule

// File: source/isa_pkg.sv
package isa_pkg;

   ///////////////////////////////////////////////////////////////////////
   // widths
   ///////////////////////////////////////////////////////////////////////
   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;

   // pc advance per instruction
   localparam logic [xlen-1:0] instr_step = 4;

   ///////////////////////////////////////////////////////////////////////
   // rv32i encodings
   ///////////////////////////////////////////////////////////////////////
   localparam logic [6:0] major_op_op     = 7'b0110011;
   localparam logic [6:0] major_op_imm    = 7'b0010011;
   localparam logic [6:0] major_op_load   = 7'b0000011;
   localparam logic [6:0] major_op_store  = 7'b0100011;
   localparam logic [6:0] major_op_branch = 7'b1100011;

   localparam logic [2:0] funct3_add_sub = 3'b000;
   localparam logic [2:0] funct3_xor     = 3'b100;
   localparam logic [2:0] funct3_or      = 3'b110;
   localparam logic [2:0] funct3_and     = 3'b111;
   // lw and sw share the word width code
   localparam logic [2:0] funct3_word    = 3'b010;
   localparam logic [2:0] funct3_beq     = 3'b000;
   localparam logic [2:0] funct3_bne     = 3'b001;

   localparam logic [6:0] funct7_sub = 7'b0100000;

   // operations the core understands
   typedef enum logic [3:0] {
      op_nop, op_add, op_sub, op_and, op_or, op_xor,
      op_addi, op_lw, op_sw, op_beq, op_bne
   } opcode_e;

endpackage

// File: source/mem_stage.sv
module mem_stage (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           e_valid,
   input  isa_pkg::opcode_e               e_op,
   input  logic [isa_pkg::reg_addr_w-1:0] e_rd,
   input  logic [isa_pkg::xlen-1:0]       e_result,
   input  logic [isa_pkg::xlen-1:0]       e_store_data,
   output logic                           ram_en,
   output logic                           ram_we,
   output logic [core_pkg::ram_addr_w-1:0] ram_addr,
   output logic [isa_pkg::xlen-1:0]       ram_wdata,
   input  logic [isa_pkg::xlen-1:0]       ram_rdata,
   output logic                           w_en,
   output logic [isa_pkg::reg_addr_w-1:0] w_rd,
   output logic [isa_pkg::xlen-1:0]       w_data
);
   import isa_pkg::*;
   import core_pkg::*;

   logic            wb_load;
   logic [xlen-1:0] wb_result;

   // word addressed ram
   assign ram_en    = e_valid && (e_op == op_lw || e_op == op_sw);
   assign ram_we    = e_valid && e_op == op_sw;
   assign ram_addr  = e_result[ram_addr_w+1:2];
   assign ram_wdata = e_store_data;

   always_ff @(posedge clk) begin
      if (rstn) begin
         w_en <= 1'b0;
      end else begin
         w_en <= e_valid && e_rd != '0 &&
                 e_op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi, op_lw};
      end
   end

   always_ff @(posedge clk) begin
      wb_load   <= (e_op == op_lw);
      w_rd      <= e_rd;
      wb_result <= e_result;
   end

   // load data arrives one cycle after ram_en
   assign w_data = wb_load ? ram_rdata : wb_result;

endmodule

// File: source/reg_file.sv
module reg_file (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic [isa_pkg::reg_addr_w-1:0] rs1_addr,
   input  logic [isa_pkg::reg_addr_w-1:0] rs2_addr,
   output logic [isa_pkg::xlen-1:0]       rs1_data,
   output logic [isa_pkg::xlen-1:0]       rs2_data,
   input  logic                           w_en,
   input  logic [isa_pkg::reg_addr_w-1:0] w_rd,
   input  logic [isa_pkg::xlen-1:0]       w_data
);
   import isa_pkg::*;

   logic [xlen-1:0] regs [2**reg_addr_w];

   // x0 reads zero, a register being written reads the new value
   function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
      if (addr == '0) begin
         return '0;
      end else if (w_en && w_rd == addr) begin
         return w_data;
      end
      return regs[addr];
   endfunction

   assign rs1_data = read_port(rs1_addr);
   assign rs2_data = read_port(rs2_addr);

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < 2**reg_addr_w; i++) begin
            regs[i] <= '0;
         end
      end else if (w_en && w_rd != '0) begin
         regs[w_rd] <= w_data;
      end
   end

endmodule

// File: source/rv_core.sv
module rv_core (
   input  logic                            clk,
   input  logic                            rstn,
   output logic [isa_pkg::xlen-1:0]        rom_addr,
   input  logic [isa_pkg::xlen-1:0]        rom_data,
   output logic                            ram_en,
   output logic                            ram_we,
   output logic [core_pkg::ram_addr_w-1:0] ram_addr,
   output logic [isa_pkg::xlen-1:0]        ram_wdata,
   input  logic [isa_pkg::xlen-1:0]        ram_rdata
);
   import isa_pkg::*;
   import core_pkg::*;

   // hazard control
   logic     stall;
   logic     flush;
   logic     redirect;
   logic     [xlen-1:0] redirect_pc;
   fwd_src_e fwd_a;
   fwd_src_e fwd_b;

   // fetch to decode
   logic            f_valid;
   logic [xlen-1:0] f_pc;
   logic [xlen-1:0] f_instr;

   // register file ports
   logic [reg_addr_w-1:0] rs1_addr;
   logic [reg_addr_w-1:0] rs2_addr;
   logic [xlen-1:0]       rs1_data;
   logic [xlen-1:0]       rs2_data;

   // decode to execute
   logic                  d_valid;
   opcode_e               d_op;
   logic [reg_addr_w-1:0] d_rd;
   logic [reg_addr_w-1:0] d_rs1;
   logic [reg_addr_w-1:0] d_rs2;
   logic [xlen-1:0]       d_rs1_data;
   logic [xlen-1:0]       d_rs2_data;
   logic [xlen-1:0]       d_imm;
   logic [xlen-1:0]       d_pc;

   // execute to memory
   logic                  e_valid;
   opcode_e               e_op;
   logic [reg_addr_w-1:0] e_rd;
   logic [xlen-1:0]       e_result;
   logic [xlen-1:0]       e_store_data;

   // write-back
   logic                  w_en;
   logic [reg_addr_w-1:0] w_rd;
   logic [xlen-1:0]       w_data;

   ///////////////////////////////////////////////////////////////////////
   // stages
   ///////////////////////////////////////////////////////////////////////
   fetch_stage u_fetch (
      .clk         (clk),
      .rstn        (rstn),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .rom_addr    (rom_addr),
      .rom_data    (rom_data),
      .f_valid     (f_valid),
      .f_pc        (f_pc),
      .f_instr     (f_instr)
   );

   reg_file u_regs (
      .clk      (clk),
      .rstn     (rstn),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .w_en     (w_en),
      .w_rd     (w_rd),
      .w_data   (w_data)
   );

   decode_stage u_decode (
      .clk        (clk),
      .rstn       (rstn),
      .stall      (stall),
      .flush      (flush),
      .f_valid    (f_valid),
      .f_pc       (f_pc),
      .f_instr    (f_instr),
      .rs1_addr   (rs1_addr),
      .rs2_addr   (rs2_addr),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .d_valid    (d_valid),
      .d_op       (d_op),
      .d_rd       (d_rd),
      .d_rs1      (d_rs1),
      .d_rs2      (d_rs2),
      .d_rs1_data (d_rs1_data),
      .d_rs2_data (d_rs2_data),
      .d_imm      (d_imm),
      .d_pc       (d_pc)
   );

   execute_stage u_execute (
      .clk          (clk),
      .rstn         (rstn),
      .d_valid      (d_valid),
      .d_op         (d_op),
      .d_rd         (d_rd),
      .d_rs1        (d_rs1),
      .d_rs2        (d_rs2),
      .d_rs1_data   (d_rs1_data),
      .d_rs2_data   (d_rs2_data),
      .d_imm        (d_imm),
      .d_pc         (d_pc),
      .fwd_a        (fwd_a),
      .fwd_b        (fwd_b),
      .w_data       (w_data),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc),
      .e_valid      (e_valid),
      .e_op         (e_op),
      .e_rd         (e_rd),
      .e_result     (e_result),
      .e_store_data (e_store_data)
   );

   mem_stage u_mem (
      .clk          (clk),
      .rstn         (rstn),
      .e_valid      (e_valid),
      .e_op         (e_op),
      .e_rd         (e_rd),
      .e_result     (e_result),
      .e_store_data (e_store_data),
      .ram_en       (ram_en),
      .ram_we       (ram_we),
      .ram_addr     (ram_addr),
      .ram_wdata    (ram_wdata),
      .ram_rdata    (ram_rdata),
      .w_en         (w_en),
      .w_rd         (w_rd),
      .w_data       (w_data)
   );

   hazard_unit u_hazard (
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .d_valid  (d_valid),
      .d_op     (d_op),
      .d_rd     (d_rd),
      .d_rs1    (d_rs1),
      .d_rs2    (d_rs2),
      .e_valid  (e_valid),
      .e_op     (e_op),
      .e_rd     (e_rd),
      .w_en     (w_en),
      .w_rd     (w_rd),
      .redirect (redirect),
      .stall    (stall),
      .flush    (flush),
      .fwd_a    (fwd_a),
      .fwd_b    (fwd_b)
   );

endmodule
